//--- logic/palette_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

module palette_ram (
	input logic clock,
	pvr_bus_if.pal_side pal
);

	logic [`PVR_DATA_W-1:0] mem [`PVR_PAL_WORDS]; // one word per palette entry

	// write on the cpu strobe edge
	always_ff @(posedge clock) begin
		if (pal.we) begin
			mem[pal.index] <= pal.wdata;
		end
	end

	assign pal.rdata = mem[pal.index]; // async read for same-cycle cpu access

endmodule

`default_nettype wire

//--- logic/pvr_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

interface pvr_bus_if;

	logic [$clog2(`PVR_PAL_WORDS)-1:0] index; // palette word index
	logic [`PVR_DATA_W-1:0] wdata; // cpu write data
	logic we; // write strobe, window hit only
	logic [`PVR_DATA_W-1:0] rdata; // combinational read of index

	modport reg_side (
		output index,
		output wdata,
		output we,
		input  rdata
	);

	modport pal_side (
		input  index,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

`default_nettype wire

//--- logic/pvr_config.svh
`ifndef PVR_CONFIG_SVH
`define PVR_CONFIG_SVH

`define PVR_DATA_W 32 // cpu data width
`define PVR_ADDR_W 16 // cpu byte address width

`define PVR_ID_VALUE 32'h17FD11DB // device id constant
`define PVR_REVISION_VALUE 32'h00000011 // revision constant

// read-only slots
`define PVR_ID_ADDR 16'h0000
`define PVR_REVISION_ADDR 16'h0004
`define PVR_TA_LIST_STATUS_ADDR 16'h0134 // list counts, old next-opb slot

// read-write control registers
`define PVR_SOFTRESET_ADDR 16'h0008 // core and ta soft reset
`define PVR_STARTRENDER_ADDR 16'h0014 // render start
`define PVR_PARAM_BASE_ADDR 16'h0020 // isp parameter base
`define PVR_REGION_BASE_ADDR 16'h002C // region array base
`define PVR_FB_R_CTRL_ADDR 16'h0044 // fb read control
`define PVR_FB_W_CTRL_ADDR 16'h0048 // fb write control
`define PVR_FB_R_SOF1_ADDR 16'h0050 // fb read start
`define PVR_FB_R_SIZE_ADDR 16'h005C // fb xy size
`define PVR_FB_X_CLIP_ADDR 16'h0068 // pixel clip x
`define PVR_FB_Y_CLIP_ADDR 16'h006C // pixel clip y
`define PVR_TEXT_CONTROL_ADDR 16'h00E4 // texturing control
`define PVR_PAL_RAM_CTRL_ADDR 16'h0108 // palette format select
`define PVR_TA_OL_BASE_ADDR 16'h0124 // object list base
`define PVR_TA_ISP_BASE_ADDR 16'h0128 // ta parameter base
`define PVR_TA_OL_LIMIT_ADDR 16'h012C // object list limit
`define PVR_TA_ISP_LIMIT_ADDR 16'h0130 // ta parameter limit
`define PVR_TA_GLOB_TILE_CLIP_ADDR 16'h013C // global tile clip
`define PVR_TA_ALLOC_CTRL_ADDR 16'h0140 // object list control
`define PVR_TA_LIST_INIT_ADDR 16'h0144 // bit 31 restarts the list counts
`define PVR_RW_COUNT 19 // number of rw registers above

`define PVR_PAL_BASE_ADDR 16'h1000 // palette window 0x1000..0x1FFC
`define PVR_PAL_WORDS 1024 // palette depth in words

`define TA_FIFO_DEPTH 256 // ta command fifo depth

`endif

//--- logic/pvr_pkg.sv
`default_nettype none

package pvr_pkg;

	// ta command field, top three bits of every word
	typedef enum logic [2:0] {
		TA_END_OF_LIST = 3'd0,
		TA_USER_CLIP   = 3'd1,
		TA_POLYGON     = 3'd4, // polygon or modifier volume
		TA_SPRITE      = 3'd5,
		TA_VERTEX      = 3'd7 // 2, 3 and 6 are not used
	} ta_cmd_e;

	typedef struct packed {
		ta_cmd_e     cmd; // bits 31:29
		logic [28:0] opts; // per-command options
	} ta_cmd_field_t;

	typedef union packed {
		logic [31:0]   raw; // word as pushed by the cpu
		ta_cmd_field_t f; // decoded view
	} ta_word_u;

	typedef struct packed {
		logic [7:0] vertex_cnt; // 31:24
		logic [7:0] poly_cnt; // 23:16
		logic [7:0] sprite_cnt; // 15:8
		logic [4:0] uclip_cnt; // 7:3
		logic       unused_seen; // sticky, bad code popped
		logic       spare; // reads zero
		logic       eol_seen; // sticky, end of list popped
	} ta_list_status_t;

endpackage

`default_nettype wire

//--- logic/pvr_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

module pvr_reg_file import pvr_pkg::*; (
	input  logic clock,
	input  logic reset_n,
	input  logic reg_cs,
	input  logic [`PVR_ADDR_W-1:0] addr,
	input  logic [`PVR_DATA_W-1:0] wdata,
	input  logic wr,
	input  logic rd,
	output logic [`PVR_DATA_W-1:0] rdata,
	pvr_bus_if.reg_side pal,
	output logic list_init,
	input  ta_list_status_t list_status
);

	localparam int RW_COUNT = `PVR_RW_COUNT;
	localparam int IDX_W = $clog2(RW_COUNT);
	localparam int PAL_AW = $clog2(`PVR_PAL_WORDS);
	localparam int PAL_BYTES = `PVR_PAL_WORDS * 4;

	// slot order of the rw bank
	localparam logic [`PVR_ADDR_W-1:0] RW_ADDR [RW_COUNT] = '{
		`PVR_SOFTRESET_ADDR, `PVR_STARTRENDER_ADDR, `PVR_PARAM_BASE_ADDR,
		`PVR_REGION_BASE_ADDR, `PVR_FB_R_CTRL_ADDR, `PVR_FB_W_CTRL_ADDR,
		`PVR_FB_R_SOF1_ADDR, `PVR_FB_R_SIZE_ADDR, `PVR_FB_X_CLIP_ADDR,
		`PVR_FB_Y_CLIP_ADDR, `PVR_TEXT_CONTROL_ADDR, `PVR_PAL_RAM_CTRL_ADDR,
		`PVR_TA_OL_BASE_ADDR, `PVR_TA_ISP_BASE_ADDR, `PVR_TA_OL_LIMIT_ADDR,
		`PVR_TA_ISP_LIMIT_ADDR, `PVR_TA_GLOB_TILE_CLIP_ADDR, `PVR_TA_ALLOC_CTRL_ADDR,
		`PVR_TA_LIST_INIT_ADDR
	};

	logic [`PVR_DATA_W-1:0] rw_regs [RW_COUNT]; // rw register storage
	logic rw_hit; // addr names an rw register
	logic [IDX_W-1:0] rw_idx; // its slot
	logic wr_en; // cpu write this cycle
	logic pal_hit; // addr inside palette window
	logic [`PVR_ADDR_W-1:0] pal_offset; // byte offset into window
	logic [`PVR_DATA_W-1:0] rd_mux;

	assign wr_en = reg_cs && wr;

	always_comb begin
		rw_hit = 1'b0;
		rw_idx = '0;
		for (int i = 0; i < RW_COUNT; i++) begin
			if (addr == RW_ADDR[i]) begin
				rw_hit = 1'b1;
				rw_idx = IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < RW_COUNT; i++) begin
				rw_regs[i] <= '0; // all rw regs clear
			end
		end else if (wr_en && rw_hit) begin
			rw_regs[rw_idx] <= wdata; // readable from next cycle
		end
	end

	// clears the decoder counts at this same edge
	assign list_init = wr_en && (addr == `PVR_TA_LIST_INIT_ADDR) && wdata[`PVR_DATA_W-1];

	// palette window steering
	assign pal_hit = (addr >= `PVR_PAL_BASE_ADDR) && (addr < `PVR_PAL_BASE_ADDR + PAL_BYTES);
	assign pal_offset = addr - `PVR_PAL_BASE_ADDR;
	assign pal.index = pal_offset[PAL_AW+1:2]; // word aligned
	assign pal.wdata = wdata;
	assign pal.we = wr_en && pal_hit;

	// read mux, anything unmapped reads zero
	always_comb begin
		rd_mux = '0;
		if (pal_hit) begin
			rd_mux = pal.rdata;
		end else if (rw_hit) begin
			rd_mux = rw_regs[rw_idx];
		end else begin
			case (addr)
				`PVR_ID_ADDR: rd_mux = `PVR_ID_VALUE;
				`PVR_REVISION_ADDR: rd_mux = `PVR_REVISION_VALUE;
				`PVR_TA_LIST_STATUS_ADDR: rd_mux = list_status; // live decoder counts
				default: rd_mux = '0;
			endcase
		end
	end

	assign rdata = (reg_cs && rd) ? rd_mux : '0; // same-cycle read

	// decoder expects a single-edge clear per init write
	a_list_init_pulse: assert property (@(posedge clock) disable iff (!reset_n)
		list_init |=> !list_init);

endmodule

`default_nettype wire

//--- logic/pvr_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

module pvr_top import pvr_pkg::*; (
	input  logic clock,
	input  logic reset_n,
	input  logic pvr_reg_cs,
	input  logic [`PVR_ADDR_W-1:0] pvr_addr,
	input  logic [`PVR_DATA_W-1:0] pvr_din,
	input  logic pvr_rd,
	input  logic pvr_wr,
	output logic [`PVR_DATA_W-1:0] pvr_dout,
	input  logic ta_fifo_wr,
	output logic ta_list_done
);

	ta_list_status_t list_status; // decoder counts back to the cpu
	logic list_init; // init write pulse

	pvr_bus_if pal_bus (); // reg file to palette
	ta_fifo_if ta_q (); // fifo to decoder

	pvr_reg_file u_reg_file (
		.clock      (clock),
		.reset_n    (reset_n),
		.reg_cs     (pvr_reg_cs),
		.addr       (pvr_addr),
		.wdata      (pvr_din),
		.wr         (pvr_wr),
		.rd         (pvr_rd),
		.rdata      (pvr_dout),
		.pal        (pal_bus.reg_side),
		.list_init  (list_init),
		.list_status(list_status)
	);

	palette_ram u_palette_ram (
		.clock(clock),
		.pal  (pal_bus.pal_side)
	);

	ta_fifo u_ta_fifo (
		.clock    (clock),
		.reset_n  (reset_n),
		.push     (ta_fifo_wr),
		.push_data(pvr_din), // ta words share the cpu data bus
		.q        (ta_q.fifo_side)
	);

	ta_cmd_decoder u_ta_cmd_decoder (
		.clock      (clock),
		.reset_n    (reset_n),
		.q          (ta_q.dec_side),
		.list_init  (list_init),
		.list_status(list_status),
		.list_done  (ta_list_done)
	);

endmodule

`default_nettype wire

//--- logic/ta_cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module ta_cmd_decoder import pvr_pkg::*; (
	input  logic clock,
	input  logic reset_n,
	ta_fifo_if.dec_side q,
	input  logic list_init,
	output ta_list_status_t list_status,
	output logic list_done
);

	ta_word_u word; // head word, two views
	ta_list_status_t status_next;
	logic eol_pop; // end-of-list word leaves this edge

	assign q.pop = !q.empty; // drain one word per cycle
	assign word = q.data;
	assign eol_pop = q.pop && (word.f.cmd == TA_END_OF_LIST);

	always_comb begin
		if (list_init) begin
			status_next = '0; // init first, same-cycle pop counts after
		end else begin
			status_next = list_status;
		end
		if (q.pop) begin
			case (word.f.cmd)
				TA_END_OF_LIST: status_next.eol_seen = 1'b1;
				TA_USER_CLIP: status_next.uclip_cnt = status_next.uclip_cnt + 5'd1;
				TA_POLYGON: status_next.poly_cnt = status_next.poly_cnt + 8'd1;
				TA_SPRITE: status_next.sprite_cnt = status_next.sprite_cnt + 8'd1;
				TA_VERTEX: status_next.vertex_cnt = status_next.vertex_cnt + 8'd1;
				default: status_next.unused_seen = 1'b1; // codes 2, 3, 6
			endcase
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			list_status <= '0;
			list_done <= 1'b0;
		end else begin
			list_status <= status_next; // counts wrap
			list_done <= eol_pop; // counts final when this is high
		end
	end

	// popped word must be fully known
	a_word_known: assert property (@(posedge clock) disable iff (!reset_n)
		q.pop |-> !$isunknown(word.raw));

endmodule

`default_nettype wire

//--- logic/ta_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

module ta_fifo (
	input logic clock,
	input logic reset_n,
	input logic push,
	input logic [`PVR_DATA_W-1:0] push_data,
	ta_fifo_if.fifo_side q
);

	localparam int AW = $clog2(`TA_FIFO_DEPTH);

	logic [`PVR_DATA_W-1:0] mem [`TA_FIFO_DEPTH]; // circular buffer
	logic [AW:0] wr_ptr; // extra msb tells full from empty
	logic [AW:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push && !q.full; // push while full is dropped
	assign do_pop = q.pop && !q.empty;

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr[AW-1:0]] <= push_data;
		end
	end

	assign q.data = mem[rd_ptr[AW-1:0]]; // show-ahead head word
	assign q.empty = (wr_ptr == rd_ptr);
	assign q.full = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);
	assign q.level = wr_ptr - rd_ptr;

	a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset_n)
		q.pop |-> !q.empty);
	// single writer against one-per-cycle drain never fills
	a_no_push_full: assert property (@(posedge clock) disable iff (!reset_n)
		push |-> !q.full);

endmodule

`default_nettype wire

//--- logic/ta_fifo_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

interface ta_fifo_if;

	logic [`PVR_DATA_W-1:0] data; // head word, valid while not empty
	logic empty;
	logic full;
	logic [$clog2(`TA_FIFO_DEPTH):0] level; // words held, 0..depth
	logic pop; // head leaves at this edge

	modport fifo_side (
		output data,
		output empty,
		output full,
		output level,
		input  pop
	);

	modport dec_side (
		input  data,
		input  empty,
		input  full,
		input  level,
		output pop
	);

endinterface

`default_nettype wire

//--- pvr_regs.f
+incdir+logic
logic/pvr_pkg.sv
logic/pvr_bus_if.sv
logic/ta_fifo_if.sv
logic/pvr_reg_file.sv
logic/palette_ram.sv
logic/ta_fifo.sv
logic/ta_cmd_decoder.sv
logic/pvr_top.sv
sim/pvr_tb.sv

//--- sim/pvr_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pvr_config.svh"

module pvr_tb;

	localparam int CLK_HALF = 10; // 20 ns period
	localparam int SKEW = 2; // inputs move this long after the edge
	// worst case per phase: reset, id, rw, read-only, palette, lists, init
	localparam int STIM_CYCLES = 3 + 44 + 1400 + 130 + 2100 + 2300 + 900;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;
	localparam int DONE_WAIT = `TA_FIFO_DEPTH + 16; // drain bound for one list

	logic clock;
	logic reset_n;
	logic pvr_reg_cs;
	logic [`PVR_ADDR_W-1:0] pvr_addr;
	logic [`PVR_DATA_W-1:0] pvr_din;
	logic pvr_rd;
	logic pvr_wr;
	logic [`PVR_DATA_W-1:0] pvr_dout;
	logic ta_fifo_wr;
	logic ta_list_done;

	integer seed = 32'hdeb0;
	int cycle_cnt = 0;
	int done_seen = 0; // list_done pulses observed
	int done_expected = 0; // end-of-list words pushed

	logic [`PVR_ADDR_W-1:0] rw_addrs [`PVR_RW_COUNT]; // kept rw map
	logic [`PVR_DATA_W-1:0] reg_img [logic [`PVR_ADDR_W-1:0]]; // register image
	logic [`PVR_DATA_W-1:0] pal_img [`PVR_PAL_WORDS]; // palette image
	int pal_written [$]; // indices safe to read back
	logic [7:0] exp_vtx, exp_poly, exp_spr; // model counts, wrap like hw
	logic [4:0] exp_uclip;
	logic exp_unused, exp_eol; // sticky

	pvr_top dut_i (.*);

	always #CLK_HALF clock = ~clock;

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) fail_run("run did not finish within the cycle limit");
	end

	always @(negedge clock) if (reset_n && ta_list_done) done_seen++; // one-cycle pulse

	function automatic int pick_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic bus_idle();
		pvr_reg_cs = 1'b0;
		pvr_wr = 1'b0;
		pvr_rd = 1'b0;
		ta_fifo_wr = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#SKEW bus_idle(); // earlier access lands at this edge
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clock);
		#SKEW;
		bus_idle();
		pvr_reg_cs = 1'b1;
		pvr_wr = 1'b1;
		pvr_addr = addr;
		pvr_din = data;
		idle_cycles(1);
	endtask

	task automatic cpu_read_check(input logic [15:0] addr, input logic [31:0] exp);
		@(posedge clock);
		#SKEW;
		bus_idle();
		pvr_reg_cs = 1'b1;
		pvr_rd = 1'b1;
		pvr_addr = addr;
		@(negedge clock); // same-cycle read has settled
		check($sformatf("pvr_dout(addr %h)", addr), pvr_dout, exp);
		idle_cycles(1);
	endtask

	task automatic push_word(input logic [31:0] w);
		@(posedge clock);
		#SKEW;
		bus_idle(); // cs low so the shared data bus hits no register
		ta_fifo_wr = 1'b1;
		pvr_din = w;
	endtask

	task automatic tally(input logic [2:0] code);
		case (code)
			3'd0: begin
				exp_eol = 1'b1;
				done_expected++;
			end
			3'd1: exp_uclip = exp_uclip + 5'd1;
			3'd4: exp_poly = exp_poly + 8'd1;
			3'd5: exp_spr = exp_spr + 8'd1;
			3'd7: exp_vtx = exp_vtx + 8'd1;
			default: exp_unused = 1'b1; // 2, 3, 6
		endcase
	endtask

	task automatic clear_tally();
		{exp_vtx, exp_poly, exp_spr, exp_uclip, exp_unused, exp_eol} = '0;
	endtask

	task automatic run_list();
		int n;
		int gappy;
		logic [31:0] w;
		n = 10 + pick_below(60);
		gappy = pick_below(2); // back to back or with gaps
		for (int i = 0; i < n; i++) begin
			w = $random(seed); // random option bits
			w[31:29] = (i == n - 1) ? 3'd0 : 3'(pick_below(8));
			tally(w[31:29]);
			push_word(w);
			if (gappy != 0) idle_cycles(pick_below(3));
		end
		idle_cycles(1);
		for (int waited = 0; done_seen < done_expected; waited++) begin
			if (waited > DONE_WAIT) fail_run("ta_list_done never pulsed after an end-of-list word");
			@(negedge clock);
			#1; // let the pulse counter update first
		end
		check("ta_list_done pulse count", done_seen, done_expected);
		cpu_read_check(`PVR_TA_LIST_STATUS_ADDR,
			{exp_vtx, exp_poly, exp_spr, exp_uclip, exp_unused, 1'b0, exp_eol});
	endtask

	initial begin
		logic [15:0] a;
		logic [31:0] d;
		int idx;
		clock = 1'b0;
		reset_n = 1'b0;
		bus_idle();
		pvr_addr = '0;
		pvr_din = '0;
		rw_addrs = '{`PVR_SOFTRESET_ADDR, `PVR_STARTRENDER_ADDR, `PVR_PARAM_BASE_ADDR,
			`PVR_REGION_BASE_ADDR, `PVR_FB_R_CTRL_ADDR, `PVR_FB_W_CTRL_ADDR, `PVR_FB_R_SOF1_ADDR,
			`PVR_FB_R_SIZE_ADDR, `PVR_FB_X_CLIP_ADDR, `PVR_FB_Y_CLIP_ADDR, `PVR_TEXT_CONTROL_ADDR,
			`PVR_PAL_RAM_CTRL_ADDR, `PVR_TA_OL_BASE_ADDR, `PVR_TA_ISP_BASE_ADDR,
			`PVR_TA_OL_LIMIT_ADDR, `PVR_TA_ISP_LIMIT_ADDR, `PVR_TA_GLOB_TILE_CLIP_ADDR,
			`PVR_TA_ALLOC_CTRL_ADDR, `PVR_TA_LIST_INIT_ADDR};
		foreach (rw_addrs[i]) reg_img[rw_addrs[i]] = '0; // rw regs reset to zero
		clear_tally();
		repeat (3) @(posedge clock);
		#SKEW reset_n = 1'b1;

		// reset values
		cpu_read_check(`PVR_ID_ADDR, `PVR_ID_VALUE);
		cpu_read_check(`PVR_REVISION_ADDR, `PVR_REVISION_VALUE);
		cpu_read_check(`PVR_TA_LIST_STATUS_ADDR, '0);
		foreach (rw_addrs[i]) cpu_read_check(rw_addrs[i], '0);

		// random rw traffic, read back later
		repeat (200) begin
			a = rw_addrs[pick_below(`PVR_RW_COUNT)];
			d = $random(seed);
			cpu_write(a, d);
			reg_img[a] = d;
			idle_cycles(pick_below(4));
			cpu_read_check(a, reg_img[a]);
		end

		// read-only and unmapped writes are ignored
		cpu_write(`PVR_ID_ADDR, $random(seed));
		cpu_write(`PVR_REVISION_ADDR, $random(seed));
		cpu_write(`PVR_TA_LIST_STATUS_ADDR, $random(seed));
		repeat (16) begin
			do begin
				a = 16'(pick_below(65536)) & 16'hFFFC;
			end while (reg_img.exists(a) || a == `PVR_ID_ADDR || a == `PVR_REVISION_ADDR ||
				a == `PVR_TA_LIST_STATUS_ADDR ||
				(a >= `PVR_PAL_BASE_ADDR && a < `PVR_PAL_BASE_ADDR + 4 * `PVR_PAL_WORDS));
			cpu_write(a, $random(seed) | 32'h1);
			cpu_read_check(a, '0);
		end
		cpu_read_check(`PVR_ID_ADDR, `PVR_ID_VALUE);
		cpu_read_check(`PVR_REVISION_ADDR, `PVR_REVISION_VALUE);
		cpu_read_check(`PVR_TA_LIST_STATUS_ADDR, '0);
		foreach (rw_addrs[i]) cpu_read_check(rw_addrs[i], reg_img[rw_addrs[i]]);

		// palette window
		repeat (300) begin
			idx = pick_below(`PVR_PAL_WORDS);
			d = $random(seed);
			cpu_write(`PVR_PAL_BASE_ADDR + 16'(idx * 4), d);
			pal_img[idx] = d;
			pal_written.push_back(idx);
			idle_cycles(pick_below(4));
			idx = pal_written[pick_below(pal_written.size())]; // only entries already written
			cpu_read_check(`PVR_PAL_BASE_ADDR + 16'(idx * 4), pal_img[idx]);
		end

		// ta lists, counts accumulate and wrap
		repeat (8) run_list();

		// list init clears the counts
		d = $random(seed) | 32'h8000_0000;
		cpu_write(`PVR_TA_LIST_INIT_ADDR, d);
		reg_img[`PVR_TA_LIST_INIT_ADDR] = d;
		clear_tally();
		cpu_read_check(`PVR_TA_LIST_STATUS_ADDR, '0);
		cpu_read_check(`PVR_TA_LIST_INIT_ADDR, d);
		repeat (3) run_list();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
